/* common/mc_consts.svh */
////////////////////
// widths, credit depth and apb
// register offsets for the mc_edge link
////////////////////
`ifndef MC_CONSTS_SVH
`define MC_CONSTS_SVH

// request address and payload widths
`define MC_ADDR_WIDTH 8
`define MC_DATA_WIDTH 16

// node coordinate widths
`define MC_X_WIDTH 2
`define MC_Y_WIDTH 2

// hardware ceiling on outstanding credits, counter holds 0..8
`define MC_CREDIT_MAX 8
`define MC_CREDIT_WIDTH 4

// errant packet counter width
`define MC_CNT_WIDTH 16

// apb register offsets
`define MC_REG_CTRL 8'h00
`define MC_REG_LIMIT 8'h04
`define MC_REG_STATUS 8'h08
`define MC_REG_ERR 8'h0C

`endif

/* common/mc_pkg.sv */
////////////////////
// packet type, forward and return
// packets, shared link word
////////////////////
`include "mc_consts.svh"

package mc_pkg;

   // packet kinds carried on the link
   typedef enum logic [1:0]
   {
      pkt_write  = 2'd0,
      pkt_read   = 2'd1,
      pkt_credit = 2'd2
   } pkt_type_e;

   // forward request, 34 bits
   typedef struct packed
   {
      pkt_type_e                 pkt_type;
      logic [`MC_ADDR_WIDTH-1:0] addr;
      logic [`MC_DATA_WIDTH-1:0] data;
      logic [`MC_X_WIDTH-1:0]    dst_x;
      logic [`MC_Y_WIDTH-1:0]    dst_y;
      logic [`MC_X_WIDTH-1:0]    src_x;
      logic [`MC_Y_WIDTH-1:0]    src_y;
   } fwd_packet_s;

   // return packet, padded up to the forward width
   typedef struct packed
   {
      pkt_type_e                 pkt_type;
      logic [`MC_DATA_WIDTH-1:0] data;
      logic [`MC_X_WIDTH-1:0]    dst_x;
      logic [`MC_Y_WIDTH-1:0]    dst_y;
      logic [`MC_ADDR_WIDTH+`MC_X_WIDTH+`MC_Y_WIDTH-1:0] pad;
   } return_packet_s;

   // one link word, read as fwd on forward channels and rev on return channels
   typedef union packed
   {
      fwd_packet_s    fwd;
      return_packet_s rev;
   } link_word_u;

endpackage

/* design/mc_edge_top.sv */
////////////////////
// mc_edge top level: apb config,
// endpoint, router and east tieoff
////////////////////
`include "mc_consts.svh"

module mc_edge_top
(
   input  logic                      clk_i,
   input  logic                      reset_i,
   // request injection
   input  logic                      req_v,
   input  logic [`MC_ADDR_WIDTH-1:0] req_addr,
   input  logic [`MC_DATA_WIDTH-1:0] req_data,
   input  logic [`MC_X_WIDTH-1:0]    req_dst_x,
   input  logic [`MC_Y_WIDTH-1:0]    req_dst_y,
   input  mc_pkg::pkt_type_e         req_type,
   output logic                      req_ready,
   // local delivery
   output logic                      out_v,
   output logic [`MC_ADDR_WIDTH-1:0] out_addr,
   output logic [`MC_DATA_WIDTH-1:0] out_data,
   output logic [`MC_X_WIDTH-1:0]    out_src_x,
   output logic [`MC_Y_WIDTH-1:0]    out_src_y,
   input  logic                      out_ready,
   // apb slave
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [`MC_ADDR_WIDTH-1:0] paddr,
   input  logic [`MC_DATA_WIDTH-1:0] pwdata,
   output logic [`MC_DATA_WIDTH-1:0] prdata,
   output logic                      pready
);

   // configuration fanout
   logic                        enable;
   logic [`MC_X_WIDTH-1:0]      node_x;
   logic [`MC_Y_WIDTH-1:0]      node_y;
   logic [`MC_CREDIT_WIDTH-1:0] credit_limit;
   logic [`MC_CREDIT_WIDTH-1:0] credits_used;
   logic                        errant_pulse;

   // endpoint to router
   logic               ep_fwd_v;
   mc_pkg::link_word_u ep_fwd_data;
   logic               ep_fwd_ready;

   // router to tieoff and back
   logic               east_fwd_v;
   mc_pkg::link_word_u east_fwd_data;
   logic               east_fwd_ready;
   logic               east_rev_v;
   mc_pkg::link_word_u east_rev_data;
   logic               east_rev_ready;

   // credit return toward the endpoint
   // the endpoint only counts pulses, the word stays visible here
   logic               ret_v;
   mc_pkg::link_word_u ret_data;

   mc_link_cfg cfg_i
   (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .credits_used (credits_used),
      .errant_pulse (errant_pulse),
      .prdata       (prdata),
      .pready       (pready),
      .enable       (enable),
      .node_x       (node_x),
      .node_y       (node_y),
      .credit_limit (credit_limit)
   );

   mc_endpoint_out ep_i
   (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_v        (req_v),
      .req_addr     (req_addr),
      .req_data     (req_data),
      .req_dst_x    (req_dst_x),
      .req_dst_y    (req_dst_y),
      .req_type     (req_type),
      .enable       (enable),
      .node_x       (node_x),
      .node_y       (node_y),
      .credit_limit (credit_limit),
      .ep_fwd_ready (ep_fwd_ready),
      .ret_v        (ret_v),
      .req_ready    (req_ready),
      .ep_fwd_v     (ep_fwd_v),
      .ep_fwd_data  (ep_fwd_data),
      .credits_used (credits_used)
   );

   mc_link_router rtr_i
   (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .node_x         (node_x),
      .ep_fwd_v       (ep_fwd_v),
      .ep_fwd_data    (ep_fwd_data),
      .out_ready      (out_ready),
      .east_fwd_ready (east_fwd_ready),
      .east_rev_v     (east_rev_v),
      .east_rev_data  (east_rev_data),
      .ep_fwd_ready   (ep_fwd_ready),
      .out_v          (out_v),
      .out_addr       (out_addr),
      .out_data       (out_data),
      .out_src_x      (out_src_x),
      .out_src_y      (out_src_y),
      .east_fwd_v     (east_fwd_v),
      .east_fwd_data  (east_fwd_data),
      .east_rev_ready (east_rev_ready),
      .ret_v          (ret_v),
      .ret_data       (ret_data)
   );

   mc_link_tieoff tie_i
   (
      .east_fwd_v     (east_fwd_v),
      .east_fwd_data  (east_fwd_data),
      .east_rev_ready (east_rev_ready),
      .east_fwd_ready (east_fwd_ready),
      .east_rev_v     (east_rev_v),
      .east_rev_data  (east_rev_data),
      .errant_pulse   (errant_pulse)
   );

endmodule

/* design/mc_link_cfg.sv */
////////////////////
// apb register block: control,
// credit limit, status, errant counter
////////////////////
`include "mc_consts.svh"

module mc_link_cfg
(
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  logic [`MC_ADDR_WIDTH-1:0]   paddr,
   input  logic [`MC_DATA_WIDTH-1:0]   pwdata,
   input  logic [`MC_CREDIT_WIDTH-1:0] credits_used,
   input  logic                        errant_pulse,
   output logic [`MC_DATA_WIDTH-1:0]   prdata,
   output logic                        pready,
   output logic                        enable,
   output logic [`MC_X_WIDTH-1:0]      node_x,
   output logic [`MC_Y_WIDTH-1:0]      node_y,
   output logic [`MC_CREDIT_WIDTH-1:0] credit_limit
);

   // node coordinates sit above the enable bit in ctrl
   localparam int node_x_lsb = 4;
   localparam int node_y_lsb = node_x_lsb + `MC_X_WIDTH;

   logic                     wr_en;
   logic [`MC_CNT_WIDTH-1:0] err_cnt;

   // no wait states
   assign pready = 1'b1;

   // write lands in the access phase
   assign wr_en = psel & penable & pwrite;

   // control register
   always_ff @(posedge clk_i)
   begin
      if (!reset_i)
      begin
         enable <= 1'b0;
         node_x <= '0;
         node_y <= '0;
      end
      else if (wr_en && paddr == `MC_REG_CTRL)
      begin
         enable <= pwdata[0];
         node_x <= pwdata[node_x_lsb +: `MC_X_WIDTH];
         node_y <= pwdata[node_y_lsb +: `MC_Y_WIDTH];
      end
   end

   // credit limit, clipped to the hardware ceiling
   always_ff @(posedge clk_i)
   begin
      if (!reset_i)
         credit_limit <= `MC_CREDIT_WIDTH'(4);
      else if (wr_en && paddr == `MC_REG_LIMIT)
      begin
         if (pwdata > `MC_DATA_WIDTH'(`MC_CREDIT_MAX))
            credit_limit <= `MC_CREDIT_WIDTH'(`MC_CREDIT_MAX);
         else
            credit_limit <= pwdata[`MC_CREDIT_WIDTH-1:0];
      end
   end

   // errant packets seen at the edge
   // any write clears, otherwise count up and stick at all ones
   always_ff @(posedge clk_i)
   begin
      if (!reset_i)
         err_cnt <= '0;
      else if (wr_en && paddr == `MC_REG_ERR)
         err_cnt <= '0;
      else if (errant_pulse && err_cnt != '1)
         err_cnt <= err_cnt + 1'b1;
   end

   // read mux, valid in the access cycle
   always_comb
   begin
      prdata = '0;
      case (paddr)
         `MC_REG_CTRL:
         begin
            prdata[0] = enable;
            prdata[node_x_lsb +: `MC_X_WIDTH] = node_x;
            prdata[node_y_lsb +: `MC_Y_WIDTH] = node_y;
         end
         `MC_REG_LIMIT:
            prdata[`MC_CREDIT_WIDTH-1:0] = credit_limit;
         `MC_REG_STATUS:
            prdata[`MC_CREDIT_WIDTH-1:0] = credits_used;
         `MC_REG_ERR:
            prdata = err_cnt;
         // unmapped offsets read zero
         default:
            prdata = '0;
      endcase
   end

endmodule

/* design/mc_link_tieoff.sv */
////////////////////
// east edge tieoff: absorbs
// forward packets, answers with credits
////////////////////

module mc_link_tieoff
(
   input  logic               east_fwd_v,
   input  mc_pkg::link_word_u east_fwd_data,
   input  logic               east_rev_ready,
   output logic               east_fwd_ready,
   output logic               east_rev_v,
   output mc_pkg::link_word_u east_rev_data,
   output logic               errant_pulse
);

   mc_pkg::fwd_packet_s    in_pkt;
   mc_pkg::return_packet_s credit_pkt;

   // incoming word read as a request
   assign in_pkt = east_fwd_data.fwd;

   // absorb only when the credit can leave in the same cycle
   assign east_fwd_ready = east_rev_ready;

   // credit back to whoever sent the packet, no payload
   always_comb
   begin
      credit_pkt.pkt_type = mc_pkg::pkt_credit;
      credit_pkt.data     = '0;
      credit_pkt.dst_x    = in_pkt.src_x;
      credit_pkt.dst_y    = in_pkt.src_y;
      credit_pkt.pad      = '0;
   end

   // every forward packet turns straight into a return
   assign east_rev_v        = east_fwd_v;
   assign east_rev_data.rev = credit_pkt;

   // nothing should route off the edge
   // flag each packet swallowed here
   assign errant_pulse = east_fwd_v & east_rev_ready;

endmodule

/* endpoint/mc_endpoint_out.sv */
////////////////////
// request injector with output
// register and credit counter
////////////////////
`include "mc_consts.svh"

module mc_endpoint_out
(
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        req_v,
   input  logic [`MC_ADDR_WIDTH-1:0]   req_addr,
   input  logic [`MC_DATA_WIDTH-1:0]   req_data,
   input  logic [`MC_X_WIDTH-1:0]      req_dst_x,
   input  logic [`MC_Y_WIDTH-1:0]      req_dst_y,
   input  mc_pkg::pkt_type_e           req_type,
   input  logic                        enable,
   input  logic [`MC_X_WIDTH-1:0]      node_x,
   input  logic [`MC_Y_WIDTH-1:0]      node_y,
   input  logic [`MC_CREDIT_WIDTH-1:0] credit_limit,
   input  logic                        ep_fwd_ready,
   input  logic                        ret_v,
   output logic                        req_ready,
   output logic                        ep_fwd_v,
   output mc_pkg::link_word_u          ep_fwd_data,
   output logic [`MC_CREDIT_WIDTH-1:0] credits_used
);

   logic req_fire;
   logic fwd_fire;

   // take a request only with an empty register, spare credit and enable set
   // compare with < so a lowered limit also blocks
   assign req_ready = enable & ~ep_fwd_v & (credits_used < credit_limit);
   assign req_fire  = req_v & req_ready;
   assign fwd_fire  = ep_fwd_v & ep_fwd_ready;

   // output valid, held until the router takes it
   always_ff @(posedge clk_i)
   begin
      if (!reset_i)
         ep_fwd_v <= 1'b0;
      else if (req_fire)
         ep_fwd_v <= 1'b1;
      else if (fwd_fire)
         ep_fwd_v <= 1'b0;
   end

   // packet payload, our own coordinates as source
   always_ff @(posedge clk_i)
   begin
      if (req_fire)
      begin
         ep_fwd_data.fwd.pkt_type <= req_type;
         ep_fwd_data.fwd.addr     <= req_addr;
         ep_fwd_data.fwd.data     <= req_data;
         ep_fwd_data.fwd.dst_x    <= req_dst_x;
         ep_fwd_data.fwd.dst_y    <= req_dst_y;
         ep_fwd_data.fwd.src_x    <= node_x;
         ep_fwd_data.fwd.src_y    <= node_y;
      end
   end

   // outstanding credits
   // up on a new request, down on each return pulse, both at once cancel
   always_ff @(posedge clk_i)
   begin
      if (!reset_i)
         credits_used <= '0;
      else
      begin
         case ({req_fire, ret_v})
            2'b10:
               credits_used <= credits_used + 1'b1;
            2'b01:
            begin
               // a stray return never wraps the count
               if (credits_used != '0)
                  credits_used <= credits_used - 1'b1;
            end
            default:
               credits_used <= credits_used;
         endcase
      end
   end

endmodule

/* mc_edge.f */
+incdir+common
common/mc_pkg.sv
design/mc_link_cfg.sv
endpoint/mc_endpoint_out.sv
router/mc_link_router.sv
design/mc_link_tieoff.sv
design/mc_edge_top.sv
verif/mc_edge_sva.sv
verif/mc_edge_tb.sv

/* router/mc_link_router.sv */
////////////////////
// one column router: local buffer,
// east forwarding, credit return arbiter
////////////////////
`include "mc_consts.svh"

module mc_link_router
(
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic [`MC_X_WIDTH-1:0]    node_x,
   input  logic                      ep_fwd_v,
   input  mc_pkg::link_word_u        ep_fwd_data,
   input  logic                      out_ready,
   input  logic                      east_fwd_ready,
   input  logic                      east_rev_v,
   input  mc_pkg::link_word_u        east_rev_data,
   output logic                      ep_fwd_ready,
   output logic                      out_v,
   output logic [`MC_ADDR_WIDTH-1:0] out_addr,
   output logic [`MC_DATA_WIDTH-1:0] out_data,
   output logic [`MC_X_WIDTH-1:0]    out_src_x,
   output logic [`MC_Y_WIDTH-1:0]    out_src_y,
   output logic                      east_fwd_v,
   output mc_pkg::link_word_u        east_fwd_data,
   output logic                      east_rev_ready,
   output logic                      ret_v,
   output mc_pkg::link_word_u        ret_data
);

   logic                        is_local;
   logic                        local_fire;
   logic                        deliver;
   logic [`MC_CREDIT_WIDTH-1:0] pend_q;
   logic                        local_req;
   logic                        grant_east;
   logic                        grant_local;
   logic                        prio_local_q;
   logic [`MC_X_WIDTH-1:0]      last_src_x;
   logic [`MC_Y_WIDTH-1:0]      last_src_y;
   mc_pkg::return_packet_s      local_pkt;

   // single column, so only x decides local vs east
   assign is_local   = (ep_fwd_data.fwd.dst_x == node_x);
   assign local_fire = ep_fwd_v & is_local & ep_fwd_ready;
   assign deliver    = out_v & out_ready;

   // buffer refills in the cycle it drains
   assign ep_fwd_ready = is_local ? (~out_v | out_ready) : east_fwd_ready;

   // east path is combinational
   assign east_fwd_v    = ep_fwd_v & ~is_local;
   assign east_fwd_data = ep_fwd_data;

   // one-entry local delivery buffer
   always_ff @(posedge clk_i)
   begin
      if (!reset_i)
         out_v <= 1'b0;
      else if (local_fire)
         out_v <= 1'b1;
      else if (deliver)
         out_v <= 1'b0;
   end

   always_ff @(posedge clk_i)
   begin
      if (local_fire)
      begin
         out_addr  <= ep_fwd_data.fwd.addr;
         out_data  <= ep_fwd_data.fwd.data;
         out_src_x <= ep_fwd_data.fwd.src_x;
         out_src_y <= ep_fwd_data.fwd.src_y;
      end
      // credit destination is the sender of the delivered packet
      if (deliver)
      begin
         last_src_x <= out_src_x;
         last_src_y <= out_src_y;
      end
   end

   // arbiter
   // tieoff is held off only when local credits wait and own the priority
   assign local_req      = (pend_q != '0);
   assign east_rev_ready = ~(local_req & prio_local_q);
   assign grant_east     = east_rev_v & east_rev_ready;
   assign grant_local    = local_req & ~grant_east;

   // pending local credits, queued at delivery
   always_ff @(posedge clk_i)
   begin
      if (!reset_i)
         pend_q <= '0;
      else if (deliver && !grant_local)
         pend_q <= pend_q + 1'b1;
      else if (!deliver && grant_local)
         pend_q <= pend_q - 1'b1;
   end

   // flip priority each time both sides compete
   always_ff @(posedge clk_i)
   begin
      if (!reset_i)
         prio_local_q <= 1'b0;
      else if (east_rev_v && local_req)
         prio_local_q <= ~prio_local_q;
   end

   // local credit word
   always_comb
   begin
      local_pkt.pkt_type = mc_pkg::pkt_credit;
      local_pkt.data     = '0;
      local_pkt.dst_x    = last_src_x;
      local_pkt.dst_y    = last_src_y;
      local_pkt.pad      = '0;
   end

   // one credit per pulse toward the endpoint
   assign ret_v        = grant_east | grant_local;
   assign ret_data.rev = grant_east ? east_rev_data.rev : local_pkt;

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the mc_edge testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   -f mc_edge.f \
   --top-module mc_edge_tb \
   -o mc_edge_sim

./obj_dir/mc_edge_sim | tee sim.log

# verdict comes from the log, not the exit status
if grep -qx "Done: no errors" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi

/* verif/mc_edge_sva.sv */
////////////////////
// bound assertions: credit ceiling,
// delivery hold, errant handshake
////////////////////
`include "mc_consts.svh"

module mc_edge_sva
(
   input logic                        clk_i,
   input logic                        reset_i,
   input logic [`MC_CREDIT_WIDTH-1:0] credits_used,
   input logic [`MC_CREDIT_WIDTH-1:0] credit_limit,
   input logic                        out_v,
   input logic                        out_ready,
   input logic [`MC_ADDR_WIDTH-1:0]   out_addr,
   input logic [`MC_DATA_WIDTH-1:0]   out_data,
   input logic [`MC_X_WIDTH-1:0]      out_src_x,
   input logic [`MC_Y_WIDTH-1:0]      out_src_y,
   input logic                        errant_pulse,
   input logic                        east_fwd_v,
   input logic                        east_fwd_ready,
   input mc_pkg::link_word_u          east_fwd_data,
   input logic                        ret_v,
   input mc_pkg::link_word_u          ret_data
);

   // outstanding count never passes the configured limit
   credit_ceiling: assert property (@(posedge clk_i) disable iff (!reset_i)
      credits_used <= credit_limit)
      else $error("credits_used 0x%0h above credit_limit 0x%0h", credits_used, credit_limit);

   // a stalled delivery keeps its valid and payload
   delivery_hold: assert property (@(posedge clk_i) disable iff (!reset_i)
      out_v && !out_ready |=> out_v && $stable(out_addr) && $stable(out_data)
         && $stable(out_src_x) && $stable(out_src_y))
      else $error("out_v or its payload changed while out_ready was low");

   // errant pulse only on a real transfer into the tieoff
   // its credit reaches the endpoint in the same cycle, addressed to the sender
   errant_on_transfer: assert property (@(posedge clk_i) disable iff (!reset_i)
      errant_pulse |-> east_fwd_v && east_fwd_ready && ret_v
         && ret_data.rev.pkt_type == mc_pkg::pkt_credit
         && ret_data.rev.dst_x == east_fwd_data.fwd.src_x
         && ret_data.rev.dst_y == east_fwd_data.fwd.src_y)
      else $error("errant_pulse without an east transfer and its credit return");

endmodule

bind mc_edge_top mc_edge_sva sva_i
(
   .clk_i          (clk_i),
   .reset_i        (reset_i),
   .credits_used   (credits_used),
   .credit_limit   (credit_limit),
   .out_v          (out_v),
   .out_ready      (out_ready),
   .out_addr       (out_addr),
   .out_data       (out_data),
   .out_src_x      (out_src_x),
   .out_src_y      (out_src_y),
   .errant_pulse   (errant_pulse),
   .east_fwd_v     (east_fwd_v),
   .east_fwd_ready (east_fwd_ready),
   .east_fwd_data  (east_fwd_data),
   .ret_v          (ret_v),
   .ret_data       (ret_data)
);

/* verif/mc_edge_tb.sv */
////////////////////
// mc_edge testbench: apb tasks,
// stimulus table, delivery monitor
////////////////////
`include "mc_consts.svh"

module mc_edge_tb;

   localparam int n_rows = 8;
   localparam int timeout_cycles = 200;
   localparam logic [1:0] node_x_cfg = 2'd1;
   localparam logic [1:0] node_y_cfg = 2'd2;
   // ctrl word: node y in 7:6, node x in 5:4, enable in bit 0
   localparam logic [15:0] ctrl_on  = {8'h00, node_y_cfg, node_x_cfg, 3'b000, 1'b1};
   localparam logic [15:0] ctrl_off = {8'h00, node_y_cfg, node_x_cfg, 3'b000, 1'b0};

   // row: local flag [28], type [27:26], dst x [25:24], addr [23:16], data [15:0]
   localparam logic [28:0] stim_tab [n_rows] = '{
      {1'b1, 2'd0, 2'd1, 8'h10, 16'h1234},
      {1'b0, 2'd0, 2'd3, 8'h22, 16'hbeef},
      {1'b1, 2'd1, 2'd1, 8'h34, 16'h0f0f},
      {1'b1, 2'd0, 2'd1, 8'h46, 16'ha5a5},
      {1'b0, 2'd1, 2'd0, 8'h58, 16'h0001},
      {1'b1, 2'd0, 2'd1, 8'h6a, 16'hffff},
      {1'b0, 2'd0, 2'd2, 8'h7c, 16'h4321},
      {1'b1, 2'd1, 2'd1, 8'h8e, 16'h5a5a}
   };

   logic                      clk_i = 1'b0;
   logic                      reset_i;
   logic                      req_v;
   logic [`MC_ADDR_WIDTH-1:0] req_addr;
   logic [`MC_DATA_WIDTH-1:0] req_data;
   logic [`MC_X_WIDTH-1:0]    req_dst_x;
   logic [`MC_Y_WIDTH-1:0]    req_dst_y;
   mc_pkg::pkt_type_e         req_type;
   logic                      req_ready;
   logic                      out_v;
   logic [`MC_ADDR_WIDTH-1:0] out_addr;
   logic [`MC_DATA_WIDTH-1:0] out_data;
   logic [`MC_X_WIDTH-1:0]    out_src_x;
   logic [`MC_Y_WIDTH-1:0]    out_src_y;
   logic                      out_ready = 1'b1;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   logic [`MC_ADDR_WIDTH-1:0] paddr;
   logic [`MC_DATA_WIDTH-1:0] pwdata;
   logic [`MC_DATA_WIDTH-1:0] prdata;
   logic                      pready;

   // 0 always ready, 1 random stalls, 2 held low
   int          stall_mode = 0;
   integer      seed = 32'h39c6;
   logic [31:0] rnd;
   int          errors = 0;
   int          errors_at_start = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   // deliveries seen and deliveries expected, in order
   logic [`MC_ADDR_WIDTH-1:0] got_addr[$];
   logic [`MC_DATA_WIDTH-1:0] got_data[$];
   logic [3:0]                got_src[$];
   logic [`MC_ADDR_WIDTH-1:0] exp_addr[$];
   logic [`MC_DATA_WIDTH-1:0] exp_data[$];

   mc_edge_top dut_i
   (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .req_v     (req_v),
      .req_addr  (req_addr),
      .req_data  (req_data),
      .req_dst_x (req_dst_x),
      .req_dst_y (req_dst_y),
      .req_type  (req_type),
      .req_ready (req_ready),
      .out_v     (out_v),
      .out_addr  (out_addr),
      .out_data  (out_data),
      .out_src_x (out_src_x),
      .out_src_y (out_src_y),
      .out_ready (out_ready),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready)
   );

   always #5 clk_i = ~clk_i;

   // out_ready set on the falling edge; out_v is a register, so a
   // transfer on the next rising edge is already known here
   always @(negedge clk_i)
   begin
      if (stall_mode == 1)
      begin
         rnd = $random(seed);
         out_ready = rnd[0];
      end
      else
         out_ready = (stall_mode == 0);
      if (out_v && out_ready)
      begin
         got_addr.push_back(out_addr);
         got_data.push_back(out_data);
         got_src.push_back({out_src_y, out_src_x});
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("%s", msg);
      errors++;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors != errors_at_start)
      begin
         tests_failed++;
         $display("test %s: failed", name);
      end
      else
         $display("test %s: passed", name);
      errors_at_start = errors;
   endtask

   // setup phase, then access phase with no wait states
   task automatic apb_write(input logic [7:0] addr, input logic [15:0] data);
      @(negedge clk_i);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = 1'b1;
      paddr = addr;
      pwdata = data;
      @(negedge clk_i);
      penable = 1'b1;
      @(negedge clk_i);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   // prdata follows paddr and registers, stable through the access cycle
   task automatic apb_read(input logic [7:0] addr, output logic [15:0] data);
      @(negedge clk_i);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = addr;
      @(negedge clk_i);
      penable = 1'b1;
      data = prdata;
      if (pready !== 1'b1)
         report_failure("apb access phase without pready");
      @(negedge clk_i);
      psel = 1'b0;
      penable = 1'b0;
   endtask

   // req_ready only changes on rising edges, so one look per falling edge
   task automatic send_req(input logic [1:0] dst_x, input logic [1:0] typ,
                           input logic [7:0] addr, input logic [15:0] data,
                           input int limit, output bit ok);
      int n;
      n = 0;
      ok = 1'b0;
      @(negedge clk_i);
      while (!req_ready && n < limit)
      begin
         @(negedge clk_i);
         n++;
      end
      if (req_ready)
      begin
         req_v = 1'b1;
         req_addr = addr;
         req_data = data;
         req_dst_x = dst_x;
         req_dst_y = 2'd0;
         req_type = mc_pkg::pkt_type_e'(typ);
         @(negedge clk_i);
         req_v = 1'b0;
         ok = 1'b1;
      end
   endtask

   task automatic wait_deliveries(input int n, output bit ok);
      int t;
      t = 0;
      @(posedge clk_i);
      while (got_addr.size() < n && t < timeout_cycles)
      begin
         @(posedge clk_i);
         t++;
      end
      ok = (got_addr.size() >= n);
   endtask

   task automatic wait_credits_zero(output bit ok);
      logic [15:0] rd;
      int          t;
      t = 0;
      apb_read(`MC_REG_STATUS, rd);
      while (rd != 16'h0 && t < 50)
      begin
         apb_read(`MC_REG_STATUS, rd);
         t++;
      end
      ok = (rd == 16'h0);
   endtask

   task automatic compare_deliveries();
      check_value("delivery count", got_addr.size(), exp_addr.size());
      for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++)
      begin
         check_value($sformatf("out_addr[%0d]", i), got_addr[i], exp_addr[i]);
         check_value($sformatf("out_data[%0d]", i), got_data[i], exp_data[i]);
         check_value($sformatf("out_src[%0d]", i), got_src[i], {node_y_cfg, node_x_cfg});
      end
   endtask

   task automatic clear_queues();
      got_addr.delete();
      got_data.delete();
      got_src.delete();
      exp_addr.delete();
      exp_data.delete();
   endtask

   // watchdog over the whole run
   initial
   begin
      #200000;
      $display("timeout: simulation did not finish");
      $display("Done: errors found");
      $finish;
   end

   initial
   begin
      logic [15:0] rd;
      logic [28:0] row;
      bit          ok;
      bit          credits_ok;
      int          n_local;
      int          n_edge;
      int          accepted;
      int          seen_ready;
      reset_i = 1'b0;
      req_v = 1'b0;
      req_addr = '0;
      req_data = '0;
      req_dst_x = '0;
      req_dst_y = '0;
      req_type = mc_pkg::pkt_write;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b1;

      // reset values, readback, limit clip, unmapped offset
      apb_read(`MC_REG_CTRL, rd);
      check_value("ctrl", rd, 16'h0);
      apb_read(`MC_REG_LIMIT, rd);
      check_value("credit_limit", rd, 16'h4);
      apb_read(`MC_REG_STATUS, rd);
      check_value("credits_used", rd, 16'h0);
      apb_read(`MC_REG_ERR, rd);
      check_value("errant count", rd, 16'h0);
      apb_write(`MC_REG_CTRL, ctrl_on);
      apb_read(`MC_REG_CTRL, rd);
      check_value("ctrl", rd, ctrl_on);
      apb_write(`MC_REG_LIMIT, 16'h3);
      apb_read(`MC_REG_LIMIT, rd);
      check_value("credit_limit", rd, 16'h3);
      apb_write(`MC_REG_LIMIT, 16'h20);
      apb_read(`MC_REG_LIMIT, rd);
      check_value("credit_limit", rd, `MC_CREDIT_MAX);
      apb_read(8'h10, rd);
      check_value("unmapped prdata", rd, 16'h0);
      end_test("reset and registers");

      // table run with random delivery stalls
      stall_mode = 1;
      clear_queues();
      n_local = 0;
      n_edge = 0;
      for (int i = 0; i < n_rows; i++)
      begin
         row = stim_tab[i];
         send_req(row[25:24], row[27:26], row[23:16], row[15:0], timeout_cycles, ok);
         if (!ok)
            report_failure($sformatf("table row %0d was never accepted", i));
         if (row[28])
         begin
            exp_addr.push_back(row[23:16]);
            exp_data.push_back(row[15:0]);
            n_local++;
         end
         else
            n_edge++;
      end
      wait_deliveries(n_local, ok);
      if (!ok)
         report_failure("local deliveries did not all arrive in time");
      wait_credits_zero(credits_ok);
      compare_deliveries();
      end_test("local delivery");

      apb_read(`MC_REG_ERR, rd);
      check_value("errant count", rd, n_edge);
      apb_write(`MC_REG_ERR, 16'h0);
      apb_read(`MC_REG_ERR, rd);
      check_value("errant count", rd, 16'h0);
      end_test("edge tieoff");

      if (!credits_ok)
         report_failure("outstanding credits never returned to zero");
      apb_read(`MC_REG_STATUS, rd);
      check_value("credits_used", rd, 16'h0);
      end_test("credit return");

      // limit of 2 with delivery held off
      stall_mode = 2;
      apb_write(`MC_REG_LIMIT, 16'h2);
      clear_queues();
      accepted = 0;
      for (int i = 0; i < 4; i++)
      begin
         send_req(node_x_cfg, 2'd0, 8'hc0 + 8'(i), 16'h0b00 + 16'(i), 20, ok);
         if (ok)
         begin
            exp_addr.push_back(8'hc0 + 8'(i));
            exp_data.push_back(16'h0b00 + 16'(i));
            accepted++;
         end
      end
      if (accepted != 2)
         report_failure($sformatf("%0d requests accepted under a limit of 2", accepted));
      // first request parked at the delivery port, both credits still out
      check_value("out_v", out_v, 1'b1);
      check_value("out_addr", out_addr, 8'hc0);
      apb_read(`MC_REG_STATUS, rd);
      check_value("credits_used", rd, 16'h2);
      stall_mode = 0;
      wait_deliveries(accepted, ok);
      if (!ok)
         report_failure("held requests were not delivered after release");
      compare_deliveries();
      wait_credits_zero(ok);
      if (!ok)
         report_failure("credits did not return after release");
      apb_write(`MC_REG_LIMIT, `MC_CREDIT_MAX);
      end_test("back-pressure");

      // disabled endpoint refuses a held request
      apb_write(`MC_REG_CTRL, ctrl_off);
      clear_queues();
      seen_ready = 0;
      @(negedge clk_i);
      req_v = 1'b1;
      req_dst_x = node_x_cfg;
      req_addr = 8'he0;
      req_data = 16'hdead;
      for (int i = 0; i < 30; i++)
      begin
         @(negedge clk_i);
         if (req_ready)
            seen_ready++;
      end
      req_v = 1'b0;
      if (seen_ready != 0)
         report_failure($sformatf("req_ready high in %0d cycles while disabled", seen_ready));
      repeat (5) @(negedge clk_i);
      check_value("delivery count", got_addr.size(), 0);
      apb_read(`MC_REG_STATUS, rd);
      check_value("credits_used", rd, 16'h0);
      end_test("disable");

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule
